//--- rv64_config.svh
`ifndef RV64_CONFIG_SVH
`define RV64_CONFIG_SVH

`define XLEN  64
`define IMM_W 32

// full encodings of the privileged system instructions
`define INSTR_ECALL  32'h0000_0073
`define INSTR_EBREAK 32'h0010_0073
`define INSTR_MRET   32'h3020_0073

`endif

//--- rvIsaPkg.sv
package rvIsaPkg;

    // opcode bits 6 to 2
    typedef enum logic [4:0] {
        grpLoad   = 5'b00000,
        grpOpImm  = 5'b00100,
        grpAuipc  = 5'b00101,
        grpOpImmW = 5'b00110,
        grpStore  = 5'b01000,
        grpOp     = 5'b01100,
        grpLui    = 5'b01101,
        grpOpW    = 5'b01110,
        grpBranch = 5'b11000,
        grpJalr   = 5'b11001,
        grpJal    = 5'b11011,
        grpSystem = 5'b11100
    } opGroupE;

    // rs2 is read when bit 1 is set, x01 reads no register
    typedef enum logic [2:0] {
        fmtI = 3'b000,
        fmtJ = 3'b001,
        fmtS = 3'b010,
        fmtB = 3'b011,
        fmtU = 3'b101
    } immFmtE;

    typedef struct packed {
        logic       mExt;   // mul/div group
        logic       word;   // 32-bit op, result sign-extended
        logic       alt;    // sub, sra
        logic [2:0] funct3;
    } aluOpT;

    localparam aluOpT aluAdd   = '{mExt: 1'b0, word: 1'b0, alt: 1'b0, funct3: 3'b000};
    localparam aluOpT aluSlt   = '{mExt: 1'b0, word: 1'b0, alt: 1'b0, funct3: 3'b010};
    localparam aluOpT aluSltu  = '{mExt: 1'b0, word: 1'b0, alt: 1'b0, funct3: 3'b011};
    localparam aluOpT aluPassB = '{mExt: 1'b0, word: 1'b0, alt: 1'b1, funct3: 3'b111};

    // signedness of lt/ge comes from aluOp
    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b100,
        brNe   = 3'b101,
        brLt   = 3'b110,
        brGe   = 3'b111
    } branchE;

    typedef enum logic [1:0] {
        bSrcReg  = 2'd0,
        bSrcFour = 2'd1,   // link address
        bSrcImm  = 2'd2,
        bSrcCsr  = 2'd3
    } aluBSrcE;

    // low two bits of memOp, bit 2 selects zero extension on loads
    typedef enum logic [1:0] {
        memByte   = 2'd0,
        memHalf   = 2'd1,
        memWord   = 2'd2,
        memDouble = 2'd3
    } memSizeE;

endpackage

//--- idPipePkg.sv
`include "rv64_config.svh"

package idPipePkg;

    // fetch to decode
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
        logic             instrError;   // bus or alignment fault on fetch
    } fetchPacketT;

    // decode to execute
    typedef struct packed {
        logic [`XLEN-1:0]  pc;
        logic [`IMM_W-1:0] imm;
        logic [4:0]        rs1;
        logic [4:0]        rs2;
        logic [4:0]        rd;
        logic [11:0]       csrAddr;
        rvIsaPkg::aluOpT   aluOp;
        logic              aluASrcPc;
        rvIsaPkg::aluBSrcE aluBSrc;
        rvIsaPkg::branchE  branch;
        logic              memRead;
        logic              memWrite;
        logic [2:0]        memOp;
        logic              regWrite;
        logic              csr;
        logic              ecall;
        logic              ebreak;
        logic              mret;
        logic              illegal;
    } decodedOpT;

endpackage

//--- pipeReg.sv
`timescale 1ns/1ns

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    load,
    input  logic    hold,
    input  logic    clear,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (clear) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= load & inValid;   // drains to a bubble when idle
        end
    end

    always_ff @(posedge clk) begin
        if (load && !hold) begin
            outData <= inData;
        end
    end

    // the owning stage derives one from the other
    holdLoadExclusive: assert property (
        @(posedge clk) disable iff (!rstN) !(hold && load)
    ) else $error("pipeReg: hold and load asserted together");

endmodule

//--- opcodeDecode.sv
`timescale 1ns/1ns
`include "rv64_config.svh"

module opcodeDecode (
    input  logic [31:0]        instr,
    output logic               illegal,
    output rvIsaPkg::immFmtE   immFmt,
    output rvIsaPkg::aluOpT    aluOp,
    output logic               aluASrcPc,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output logic               csr,
    output logic               ecall,
    output logic               ebreak,
    output logic               mret,
    output rvIsaPkg::aluBSrcE  aluBSrc,
    output rvIsaPkg::branchE   branch,
    output logic [2:0]         memOp
);
    import rvIsaPkg::*;

    opGroupE    group;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       f3AddSub;
    logic       f3Sl;
    logic       f3Sr;
    logic       f7Base;
    logic       f7Alt;
    logic       f7Mul;
    logic       sysCode;
    logic       groupErr;

    assign group  = opGroupE'(instr[6:2]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign f3AddSub = (funct3 == 3'b000);
    assign f3Sl     = (funct3 == 3'b001);
    assign f3Sr     = (funct3 == 3'b101);
    assign f7Base   = (funct7 == 7'b0000000);
    assign f7Alt    = (funct7 == 7'b0100000);
    assign f7Mul    = (funct7 == 7'b0000001);

    assign ecall   = (instr == `INSTR_ECALL);
    assign ebreak  = (instr == `INSTR_EBREAK);
    assign mret    = (instr == `INSTR_MRET);
    assign sysCode = ecall | ebreak | mret;

    assign memOp     = funct3;
    assign memRead   = (group == grpLoad);
    assign memWrite  = (group == grpStore);
    assign regWrite  = (group != grpBranch) && (group != grpStore);
    assign csr       = (group == grpSystem);
    assign aluASrcPc = (group == grpAuipc) || (group == grpJal) || (group == grpJalr);

    always_comb begin
        immFmt   = fmtI;
        aluBSrc  = bSrcImm;
        aluOp    = aluAdd;
        branch   = brNone;
        groupErr = 1'b0;
        case (group)
            grpLoad: begin
                groupErr = (funct3 == {1'b1, memDouble});   // no ldu
            end
            grpStore: begin
                immFmt   = fmtS;
                groupErr = funct3[2];
            end
            grpOpImm: begin
                aluOp    = '{mExt: 1'b0, word: 1'b0, alt: funct7[5] & f3Sr, funct3: funct3};
                // 6-bit shamt leaves funct7[0] free
                groupErr = (f3Sl && funct7[6:1] != 6'b000000) ||
                           (f3Sr && funct7[6:1] != 6'b000000 && funct7[6:1] != 6'b010000);
            end
            grpOpImmW: begin
                aluOp    = '{mExt: 1'b0, word: 1'b1, alt: funct7[5] & f3Sr, funct3: funct3};
                groupErr = !(f3AddSub || (f3Sl && f7Base) || (f3Sr && (f7Base || f7Alt)));
            end
            grpOp: begin
                immFmt   = fmtS;   // R type reads both sources
                aluBSrc  = bSrcReg;
                aluOp    = '{mExt: funct7[0], word: 1'b0, alt: funct7[5], funct3: funct3};
                groupErr = !(f7Base || f7Mul || (f7Alt && (f3AddSub || f3Sr)));
            end
            grpOpW: begin
                immFmt   = fmtS;
                aluBSrc  = bSrcReg;
                aluOp    = '{mExt: funct7[0], word: 1'b1, alt: funct7[5], funct3: funct3};
                groupErr = !((f7Base && (f3AddSub || f3Sl || f3Sr)) ||
                             (f7Alt && (f3AddSub || f3Sr)) ||
                             (f7Mul && (f3AddSub || funct3[2])));
            end
            grpLui: begin
                immFmt = fmtU;
                aluOp  = aluPassB;
            end
            grpAuipc: begin
                immFmt = fmtU;
            end
            grpJal: begin
                immFmt  = fmtJ;
                aluBSrc = bSrcFour;
                branch  = brJal;
            end
            grpJalr: begin
                aluBSrc  = bSrcFour;
                branch   = brJalr;
                groupErr = !f3AddSub;
            end
            grpBranch: begin
                immFmt  = fmtB;
                aluBSrc = bSrcReg;
                aluOp   = funct3[1] ? aluSltu : aluSlt;
                case (funct3)
                    3'b000: branch = brEq;
                    3'b001: branch = brNe;
                    3'b100, 3'b110: branch = brLt;
                    3'b101, 3'b111: branch = brGe;
                    default: groupErr = 1'b1;
                endcase
            end
            grpSystem: begin
                aluBSrc  = bSrcCsr;
                aluOp    = aluPassB;
                groupErr = (funct3 == 3'b100) || (f3AddSub && !sysCode);
            end
            default: begin
                groupErr = 1'b1;
            end
        endcase
    end

    assign illegal = groupErr || (instr[1:0] != 2'b11);   // compressed space not supported

endmodule

//--- immGen.sv
`timescale 1ns/1ns
`include "rv64_config.svh"

module immGen (
    input  logic [31:7]        instrHi,
    input  rvIsaPkg::immFmtE   immFmt,
    output logic [`IMM_W-1:0]  imm
);
    import rvIsaPkg::*;

    logic signed [31:0] raw;
    logic               sign;

    assign sign = instrHi[31];

    always_comb begin
        case (immFmt)
            fmtS: begin
                raw = {{20{sign}}, instrHi[31:25], instrHi[11:7]};
            end
            fmtB: begin
                raw = {{19{sign}}, sign, instrHi[7], instrHi[30:25], instrHi[11:8], 1'b0};
            end
            fmtU: begin
                raw = {instrHi[31:12], 12'b0};
            end
            fmtJ: begin
                raw = {{11{sign}}, sign, instrHi[19:12], instrHi[20], instrHi[30:21], 1'b0};
            end
            default: begin
                raw = {{20{sign}}, instrHi[31:20]};   // I format
            end
        endcase
    end

    assign imm = raw;   // signed source, extends to IMM_W

endmodule

//--- idStage.sv
`timescale 1ns/1ns

module idStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   fetchValid,
    input  logic                   stall,
    input  logic                   flush,
    input  logic                   rs1Ready,
    input  logic                   rs2Ready,
    input  logic                   csrError,
    input  idPipePkg::fetchPacketT fetchPacket,
    output logic                   rsBlock,
    output logic                   idValid,
    output idPipePkg::decodedOpT   idOp
);
    import idPipePkg::*;
    import rvIsaPkg::*;

    logic        fetchHold;
    logic        fValid;
    fetchPacketT fPkt;
    logic [31:0] instr;
    immFmtE      immFmt;
    logic        decIllegal;
    logic        needRs1;
    logic        needRs2;
    decodedOpT   decOp;

    assign fetchHold = stall | rsBlock;

    pipeReg #(.payloadT(fetchPacketT)) fetchLatch (
        .clk      (clk),
        .rstN     (rstN),
        .load     (!fetchHold),
        .hold     (fetchHold),
        .clear    (flush),
        .inValid  (fetchValid),
        .inData   (fetchPacket),
        .outValid (fValid),
        .outData  (fPkt)
    );

    assign instr = fPkt.instr;

    opcodeDecode decodeUnit (
        .instr     (instr),
        .illegal   (decIllegal),
        .immFmt    (immFmt),
        .aluOp     (decOp.aluOp),
        .aluASrcPc (decOp.aluASrcPc),
        .memRead   (decOp.memRead),
        .memWrite  (decOp.memWrite),
        .regWrite  (decOp.regWrite),
        .csr       (decOp.csr),
        .ecall     (decOp.ecall),
        .ebreak    (decOp.ebreak),
        .mret      (decOp.mret),
        .aluBSrc   (decOp.aluBSrc),
        .branch    (decOp.branch),
        .memOp     (decOp.memOp)
    );

    immGen immUnit (
        .instrHi (instr[31:7]),
        .immFmt  (immFmt),
        .imm     (decOp.imm)
    );

    assign decOp.pc      = fPkt.pc;
    assign decOp.rs1     = instr[19:15];
    assign decOp.rs2     = instr[24:20];
    assign decOp.rd      = instr[11:7];
    assign decOp.csrAddr = instr[31:20];
    // csrError only counts for real CSR accesses
    assign decOp.illegal = decIllegal || fPkt.instrError ||
                           (decOp.csr && instr[14:12] != 3'b000 && csrError);

    assign needRs1 = (immFmt[1:0] != 2'b01);   // U and J read no register
    assign needRs2 = immFmt[1];
    assign rsBlock = fValid && !flush &&
                     ((needRs1 && !rs1Ready) || (needRs2 && !rs2Ready));

    pipeReg #(.payloadT(decodedOpT)) opLatch (
        .clk      (clk),
        .rstN     (rstN),
        .load     (!stall),
        .hold     (stall),
        .clear    (flush),
        .inValid  (fValid & ~rsBlock),   // bubble while blocked
        .inData   (decOp),
        .outValid (idValid),
        .outData  (idOp)
    );

    // fetch only strobes into an open stage
    fetchWhenOpen: assert property (
        @(posedge clk) disable iff (!rstN) fetchValid |-> !(stall || rsBlock)
    ) else $error("idStage: fetchValid while stage is stalled or blocked");

endmodule

//--- idStageTb.sv
`timescale 1ns/1ns

module idStageTb;
    import idPipePkg::*;
    import rvIsaPkg::*;

    localparam int NROWS = 28;
    localparam int PERIOD = 40;

    logic        clk;
    logic        rstN;
    logic        fetchValid;
    logic        stall;
    logic        flush;
    logic        rs1Ready;
    logic        rs2Ready;
    logic        csrError;
    fetchPacketT fetchPacket;
    logic        rsBlock;
    logic        idValid;
    decodedOpT   idOp;

    logic [31:0] rowInstr [NROWS];
    logic        rowIE [NROWS];
    logic        rowCE [NROWS];
    decodedOpT   rowExp [NROWS];
    int          rowCount;
    logic [15:0] lfsr;

    idStage UUT (
        .clk         (clk),
        .rstN        (rstN),
        .fetchValid  (fetchValid),
        .stall       (stall),
        .flush       (flush),
        .rs1Ready    (rs1Ready),
        .rs2Ready    (rs2Ready),
        .csrError    (csrError),
        .fetchPacket (fetchPacket),
        .rsBlock     (rsBlock),
        .idValid     (idValid),
        .idOp        (idOp)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NROWS * 20 + 100) * PERIOD);
        failRun("simulation timed out waiting for the decode stage");
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic checkOp(input string name, input decodedOpT got, input decodedOpT exp);
        if (got !== exp) begin
            failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    // one output bit per step, galois taps 16,14,13,11
    function automatic logic [63:0] randBits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return v;
    endfunction

    // lui, auipc and jal read no register
    function automatic logic readsReg(input logic [31:0] instr);
        return !(instr[6:2] inside {5'b01101, 5'b00101, 5'b11011});
    endfunction

    // store, branch, op and opW read rs2
    function automatic logic readsRs2(input logic [31:0] instr);
        return instr[6:2] inside {5'b01000, 5'b11000, 5'b01100, 5'b01110};
    endfunction

    // ctl is {memRead, memWrite, regWrite, csr, illegal}, sys is {ecall, ebreak, mret}
    task automatic addRow(input logic [31:0] instr, input logic ie, input logic ce,
                          input logic [31:0] imm, input logic [5:0] alu, input logic aPc,
                          input logic [1:0] bSrc, input logic [2:0] br,
                          input logic [2:0] memOp, input logic [4:0] ctl,
                          input logic [2:0] sys);
        decodedOpT e;
        e           = '0;
        e.imm       = imm;
        e.rs1       = instr[19:15];
        e.rs2       = instr[24:20];
        e.rd        = instr[11:7];
        e.csrAddr   = instr[31:20];
        e.aluOp     = aluOpT'(alu);
        e.aluASrcPc = aPc;
        e.aluBSrc   = aluBSrcE'(bSrc);
        e.branch    = branchE'(br);
        e.memOp     = memOp;
        {e.memRead, e.memWrite, e.regWrite, e.csr, e.illegal} = ctl;
        {e.ecall, e.ebreak, e.mret} = sys;
        rowInstr[rowCount] = instr;
        rowIE[rowCount]    = ie;
        rowCE[rowCount]    = ce;
        rowExp[rowCount]   = e;
        rowCount++;
    endtask

    task automatic fillTable;
        // instr        ie ce imm           alu   pc bs br mo ctl       sys
        addRow(32'hFF853283, 0, 0, 32'hFFFFFFF8, 6'h00, 0, 2, 0, 3, 5'b10100, 3'b000); // ld
        addRow(32'h00613823, 0, 0, 32'h00000010, 6'h00, 0, 2, 0, 3, 5'b01000, 3'b000); // sd
        addRow(32'hFE70AE23, 0, 0, 32'hFFFFFFFC, 6'h00, 0, 2, 0, 2, 5'b01000, 3'b000); // sw
        addRow(32'h405201B3, 0, 0, 32'h00000403, 6'h08, 0, 0, 0, 0, 5'b00100, 3'b000); // sub
        addRow(32'h025201B3, 0, 0, 32'h00000023, 6'h20, 0, 0, 0, 0, 5'b00100, 3'b000); // mul
        addRow(32'hFFF00093, 0, 0, 32'hFFFFFFFF, 6'h00, 0, 2, 0, 0, 5'b00100, 3'b000); // addi
        addRow(32'h4051D113, 0, 0, 32'h00000405, 6'h0D, 0, 2, 0, 5, 5'b00100, 3'b000); // srai
        addRow(32'h005201BB, 0, 0, 32'h00000003, 6'h10, 0, 0, 0, 0, 5'b00100, 3'b000); // addw
        addRow(32'hFFE1009B, 0, 0, 32'hFFFFFFFE, 6'h10, 0, 2, 0, 0, 5'b00100, 3'b000); // addiw
        addRow(32'h800002B7, 0, 0, 32'h80000000, 6'h0F, 0, 2, 0, 0, 5'b00100, 3'b000); // lui
        addRow(32'h12345317, 0, 0, 32'h12345000, 6'h00, 1, 2, 0, 5, 5'b00100, 3'b000); // auipc
        addRow(32'hFFDFF0EF, 0, 0, 32'hFFFFFFFC, 6'h00, 1, 1, 1, 7, 5'b00100, 3'b000); // jal
        addRow(32'h00008067, 0, 0, 32'h00000000, 6'h00, 1, 1, 2, 0, 5'b00100, 3'b000); // jalr
        addRow(32'hFE208CE3, 0, 0, 32'hFFFFFFF8, 6'h02, 0, 0, 4, 0, 5'b00000, 3'b000); // beq
        addRow(32'h0041E863, 0, 0, 32'h00000010, 6'h03, 0, 0, 6, 6, 5'b00000, 3'b000); // bltu
        addRow(32'h300312F3, 0, 0, 32'h00000300, 6'h0F, 0, 3, 0, 1, 5'b00110, 3'b000); // csrrw
        addRow(32'h300312F3, 0, 1, 32'h00000300, 6'h0F, 0, 3, 0, 1, 5'b00111, 3'b000);
        addRow(32'h00000073, 0, 0, 32'h00000000, 6'h0F, 0, 3, 0, 0, 5'b00110, 3'b100); // ecall
        addRow(32'h00100073, 0, 0, 32'h00000001, 6'h0F, 0, 3, 0, 0, 5'b00110, 3'b010); // ebreak
        addRow(32'h30200073, 0, 0, 32'h00000302, 6'h0F, 0, 3, 0, 0, 5'b00110, 3'b001); // mret
        addRow(32'h00007283, 0, 0, 32'h00000000, 6'h00, 0, 2, 0, 7, 5'b10101, 3'b000); // ldu
        addRow(32'h0000000B, 0, 0, 32'h00000000, 6'h00, 0, 2, 0, 0, 5'b00101, 3'b000);
        addRow(32'h00000001, 0, 0, 32'h00000000, 6'h00, 0, 2, 0, 0, 5'b10101, 3'b000);
        addRow(32'h00200073, 0, 0, 32'h00000002, 6'h0F, 0, 3, 0, 0, 5'b00111, 3'b000);
        addRow(32'hFFF00093, 1, 0, 32'hFFFFFFFF, 6'h00, 0, 2, 0, 0, 5'b00101, 3'b000); // fetch err
        addRow(32'hFFF00093, 0, 1, 32'hFFFFFFFF, 6'h00, 0, 2, 0, 0, 5'b00100, 3'b000);
        addRow(32'h00000073, 0, 1, 32'h00000000, 6'h0F, 0, 3, 0, 0, 5'b00110, 3'b100);
        addRow(32'h205201B3, 0, 0, 32'h00000203, 6'h00, 0, 0, 0, 0, 5'b00101, 3'b000); // bad f7
    endtask

    task automatic driveFetch(input int r, input logic [63:0] pc);
        fetchValid  <= 1'b1;
        fetchPacket <= '{pc: pc, instr: rowInstr[r], instrError: rowIE[r]};
        csrError    <= rowCE[r];
    endtask

    task automatic runRow(input int r);
        decodedOpT exp;
        int        delay;
        int        waited;
        int        expLat;
        logic      reads;
        logic      onlyRs2;
        logic      blocks;
        exp     = rowExp[r];
        exp.pc  = randBits(62) << 2;
        delay   = int'(randBits(2));
        reads   = readsReg(rowInstr[r]);
        onlyRs2 = (randBits(1) != 0) && reads;   // rs1 stays ready
        blocks  = onlyRs2 ? readsRs2(rowInstr[r]) : reads;
        if (!blocks) begin
            delay = delay | 1;   // keep ready low, must not block
        end
        expLat = blocks ? 2 + delay : 2;
        @(posedge clk);
        driveFetch(r, exp.pc);
        rs1Ready <= onlyRs2 || (delay == 0);
        rs2Ready <= (delay == 0);
        @(posedge clk);
        fetchValid <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited == 1) begin
                checkBit("rsBlock", rsBlock, blocks && delay > 0);
            end
            if (!idValid) begin
                @(posedge clk);
                if (waited == delay) begin
                    rs1Ready <= 1'b1;
                    rs2Ready <= 1'b1;
                end
            end
        end while (!idValid);
        if (waited != expLat) begin
            failRun($sformatf("row %0d took %0d cycles instead of %0d", r, waited, expLat));
        end
        checkOp("idOp", idOp, exp);
    endtask

    task automatic stallTest;
        decodedOpT opA;
        decodedOpT opB;
        opA    = rowExp[0];
        opB    = rowExp[3];
        opA.pc = randBits(62) << 2;
        opB.pc = randBits(62) << 2;
        @(posedge clk);
        rs1Ready <= 1'b1;
        rs2Ready <= 1'b1;
        driveFetch(0, opA.pc);
        @(posedge clk);
        driveFetch(3, opB.pc);   // back to back
        @(posedge clk);
        fetchValid <= 1'b0;
        stall      <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkBit("idValid", idValid, 1'b1);
            checkOp("idOp", idOp, opA);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        checkBit("idValid", idValid, 1'b1);
        checkOp("idOp", idOp, opA);
        @(negedge clk);
        checkBit("idValid", idValid, 1'b1);
        checkOp("idOp", idOp, opB);
        @(negedge clk);
        checkBit("idValid", idValid, 1'b0);
    endtask

    task automatic flushTest;
        @(posedge clk);
        driveFetch(5, randBits(62) << 2);
        @(posedge clk);
        fetchValid <= 1'b0;
        flush      <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            checkBit("idValid", idValid, 1'b0);
        end
    endtask

    initial begin
        rstN        = 1'b0;
        fetchValid  = 1'b0;
        stall       = 1'b0;
        flush       = 1'b0;
        rs1Ready    = 1'b1;
        rs2Ready    = 1'b1;
        csrError    = 1'b0;
        fetchPacket = '0;
        rowCount    = 0;
        lfsr        = 16'd42767;
        fillTable();
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkBit("idValid", idValid, 1'b0);
        checkBit("rsBlock", rsBlock, 1'b0);
        for (int r = 0; r < rowCount; r++) begin
            runRow(r);
        end
        stallTest();
        flushTest();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+.
rvIsaPkg.sv
idPipePkg.sv
pipeReg.sv
opcodeDecode.sv
immGen.sv
idStage.sv
idStageTb.sv

//--- Bender.yml
package:
  name: id_stage

sources:
  - include_dirs:
      - .
    files:
      - rvIsaPkg.sv
      - idPipePkg.sv
      - pipeReg.sv
      - opcodeDecode.sv
      - immGen.sv
      - idStage.sv
  - target: test
    include_dirs:
      - .
    files:
      - idStageTb.sv
